// ==== modem_defines.svh ====
`ifndef MODEM_DEFINES_SVH
`define MODEM_DEFINES_SVH

// Entries per word FIFO
`define FIFO_DEPTH		8

// Micro-rotation stages after the fold stage
`define CORDIC_STAGES	6

// Signed X/Y width inside the CORDIC
`define CORDIC_WIDTH	10

// Magnitude of each I or Q component
`define SYM_AMP			5

`endif

// ==== modemPkg.sv ====
`include "modem_defines.svh"

package modemPkg;

	////////////////////
	// Data types
	////////////////////
	typedef logic [3:0]			word_t;		// User data word
	typedef logic [1:0]			dibit_t;	// Bits per symbol
	typedef logic signed [3:0]	sample_t;	// One I or Q component
	typedef logic [7:0]			phase_t;	// 256 counts per full turn

	typedef struct packed {
		sample_t	i;	// In-phase
		sample_t	q;	// Quadrature
	} iqSymbol_t;

	////////////////////
	// CORDIC angles
	////////////////////
	// atan(2^-k) in phase_t units, index k is the stage shift
	parameter phase_t cordicAtan [`CORDIC_STAGES] = '{
		8'd32,	// 45.000 deg
		8'd19,	// 26.565 deg
		8'd10,	// 14.036 deg
		8'd5,	// 7.125 deg
		8'd3,	// 3.576 deg
		8'd1	// 1.790 deg
	};

endpackage

// ==== wordFifo.sv ====
`timescale 1ns/1ps
`include "modem_defines.svh"

module wordFifo #(
	parameter int DEPTH = `FIFO_DEPTH	// Entries
) (
	input	logic				inClock,
	input	logic				rst,
	input	logic				push,		// Write strobe
	input	modemPkg::word_t	pushData,
	input	logic				pop,		// Take head word
	output	modemPkg::word_t	rdData,		// Head word, FWFT
	output	logic				full,
	output	logic				empty
);
	import modemPkg::*;

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;	// Pointer width
	localparam int CNT_W = $clog2(DEPTH + 1);				// Holds 0..DEPTH

	word_t				mem [DEPTH];	// Storage array
	logic [PTR_W-1:0]	wrPtr;			// Next free slot
	logic [PTR_W-1:0]	rdPtr;			// Oldest word
	logic [CNT_W-1:0]	count;			// Occupancy
	logic				doPush;			// Accepted write
	logic				doPop;			// Accepted read

	// Wrap at DEPTH, not at a power of two
	function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	////////////////////
	// Flags and head
	////////////////////
	assign full   = (count == CNT_W'(DEPTH));
	assign empty  = (count == '0);
	assign doPush = push && !full;		// Write while full dropped
	assign doPop  = pop && !empty;		// Read while empty ignored
	assign rdData = mem[rdPtr];			// Falls through, no read latency

	////////////////////
	// Storage
	////////////////////
	always_ff @(posedge inClock) begin
		if (doPush) begin
			mem[wrPtr] <= pushData;	// Seen at read side next cycle
		end
	end

	////////////////////
	// Pointers, count
	////////////////////
	always_ff @(posedge inClock) begin
		if (rst) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (doPush) begin
				wrPtr <= nextPtr(wrPtr);
			end
			if (doPop) begin
				rdPtr <= nextPtr(rdPtr);	// Head removed at this edge
			end
			case ({doPush, doPop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;	// Idle or both
			endcase
		end
	end

endmodule

// ==== qpskCoder.sv ====
`timescale 1ns/1ps
`include "modem_defines.svh"

module qpskCoder (
	input	logic					inClock,
	input	logic					rst,
	input	modemPkg::word_t		rdData,		// FIFO head
	input	logic					empty,		// FIFO has nothing
	output	logic					pop,		// Take the head word
	output	logic					symValid,	// One symbol this cycle
	output	modemPkg::iqSymbol_t	sym
);
	import modemPkg::*;

	typedef enum logic [1:0] {
		idle,		// Waiting for a word
		sendHigh,	// High symbol on the output
		sendLow		// Low symbol on the output
	} coderState_t;

	coderState_t	state;
	dibit_t			lowDibit;	// Second half of popped word

	// Bit 1 picks I sign, bit 0 picks Q sign
	function automatic iqSymbol_t mapDibit(input dibit_t d);
		iqSymbol_t s;
		s.i = d[1] ? sample_t'(-(`SYM_AMP)) : sample_t'(`SYM_AMP);
		s.q = d[0] ? sample_t'(-(`SYM_AMP)) : sample_t'(`SYM_AMP);
		return s;
	endfunction

	assign pop = (state == idle) && !empty;	// Cycle 0 of a word

	////////////////////
	// Sequencer
	////////////////////
	always_ff @(posedge inClock) begin
		if (rst) begin
			state    <= idle;
			symValid <= 1'b0;
		end else begin
			case (state)
				idle: begin
					symValid <= pop;			// High symbol next cycle
					if (pop) begin
						state <= sendHigh;
					end
				end
				sendHigh: begin
					symValid <= 1'b1;			// Low symbol follows
					state    <= sendLow;
				end
				default: begin
					symValid <= 1'b0;			// Back to idle, 3 cycles per word
					state    <= idle;
				end
			endcase
		end
	end

	////////////////////
	// Symbol payload
	////////////////////
	always_ff @(posedge inClock) begin
		if (pop) begin
			lowDibit <= rdData[1:0];
			sym      <= mapDibit(rdData[3:2]);	// High dibit first
		end else if (state == sendHigh) begin
			sym <= mapDibit(lowDibit);
		end
	end

endmodule

// ==== cordicPhase.sv ====
`timescale 1ns/1ps
`include "modem_defines.svh"

module cordicPhase (
	input	logic					inClock,
	input	logic					rst,
	input	logic					symValid,	// New I/Q this cycle
	input	modemPkg::iqSymbol_t	sym,
	output	logic					phaseValid,	// STAGES+1 cycles later
	output	modemPkg::phase_t		phase		// atan2(Q, I), 256 per turn
);
	import modemPkg::*;

	localparam int N    = `CORDIC_STAGES;	// Rotation stages
	localparam int W    = `CORDIC_WIDTH;	// Datapath width
	localparam int FRAC = W - 6;			// Fraction bits, 6 left for sign and gain

	logic signed [W-1:0]	xPipe [N+1];	// X per stage, index 0 is fold
	logic signed [W-1:0]	yPipe [N+1];	// Y per stage
	phase_t					zPipe [N+1];	// Accumulated angle
	logic [N:0]				vPipe;			// Valid travels alongside
	logic signed [W-1:0]	xIn;
	logic signed [W-1:0]	yIn;

	////////////////////
	// Input scaling
	////////////////////
	// Sign-extend, then move up to get fraction bits for the shifts
	assign xIn = W'(sym.i) <<< FRAC;
	assign yIn = W'(sym.q) <<< FRAC;

	////////////////////
	// Datapath
	////////////////////
	always_ff @(posedge inClock) begin
		// Stage 0, fold left half-plane by 180 deg
		if (xIn < 0) begin
			xPipe[0] <= -xIn;
			yPipe[0] <= -yIn;
			zPipe[0] <= 8'd128;		// Half turn preloaded
		end else begin
			xPipe[0] <= xIn;
			yPipe[0] <= yIn;
			zPipe[0] <= '0;
		end

		// Rotation stages, drive Y toward zero
		for (int k = 1; k <= N; k++) begin
			if (yPipe[k-1] < 0) begin	// Below axis, rotate counter-clockwise
				xPipe[k] <= xPipe[k-1] - (yPipe[k-1] >>> (k - 1));
				yPipe[k] <= yPipe[k-1] + (xPipe[k-1] >>> (k - 1));
				zPipe[k] <= zPipe[k-1] - cordicAtan[k-1];
			end else begin				// On or above axis, rotate clockwise
				xPipe[k] <= xPipe[k-1] + (yPipe[k-1] >>> (k - 1));
				yPipe[k] <= yPipe[k-1] - (xPipe[k-1] >>> (k - 1));
				zPipe[k] <= zPipe[k-1] + cordicAtan[k-1];
			end
		end
	end

	////////////////////
	// Valid pipe
	////////////////////
	always_ff @(posedge inClock) begin
		if (rst) begin
			vPipe <= '0;
		end else begin
			vPipe <= {vPipe[N-1:0], symValid};	// One bit per stage
		end
	end

	assign phaseValid = vPipe[N];
	assign phase      = zPipe[N];	// Wraps mod 256 by width

endmodule

// ==== phaseDecoder.sv ====
`timescale 1ns/1ps

module phaseDecoder (
	input	logic				inClock,
	input	logic				rst,
	input	logic				phaseValid,	// From CORDIC
	input	modemPkg::phase_t	phase,
	input	logic				outFull,	// Output FIFO full
	output	logic				push,		// Word to output FIFO
	output	modemPkg::word_t	pushData,
	output	logic				overflow	// Sticky until rst
);
	import modemPkg::*;

	logic		secondHalf;	// Next dibit completes a word
	dibit_t		hiDibit;	// First dibit held
	dibit_t		rxDibit;	// Dibit of current phase

	////////////////////
	// Quadrant slicer
	////////////////////
	always_comb begin
		case (phase[7:6])	// Top two bits give quadrant
			2'd0:    rxDibit = 2'b00;	// I+, Q+
			2'd1:    rxDibit = 2'b10;	// I-, Q+
			2'd2:    rxDibit = 2'b11;	// I-, Q-
			default: rxDibit = 2'b01;	// I+, Q-
		endcase
	end

	////////////////////
	// Control
	////////////////////
	always_ff @(posedge inClock) begin
		if (rst) begin
			secondHalf <= 1'b0;
			push       <= 1'b0;
			overflow   <= 1'b0;
		end else begin
			push <= phaseValid && secondHalf;	// One cycle after second dibit
			if (phaseValid) begin
				secondHalf <= !secondHalf;
			end
			if (push && outFull) begin
				overflow <= 1'b1;				// Word lost in FIFO
			end
		end
	end

	////////////////////
	// Word assembly
	////////////////////
	always_ff @(posedge inClock) begin
		if (phaseValid && !secondHalf) begin
			hiDibit <= rxDibit;
		end
		if (phaseValid && secondHalf) begin
			pushData <= {hiDibit, rxDibit};	// High dibit arrived first
		end
	end

endmodule

// ==== modemTop.sv ====
`timescale 1ns/1ps
`include "modem_defines.svh"

module modemTop (
	input	logic				inClock,
	input	logic				rst,
	input	logic				inWrite,	// Write strobe, input side
	input	modemPkg::word_t	inData,
	output	logic				inFull,		// Stop writing
	input	logic				outRead,	// Pop one word
	output	modemPkg::word_t	outData,	// Valid while outEmpty low
	output	logic				outEmpty,
	output	logic				overflow	// Output word dropped
);
	import modemPkg::*;

	word_t		fifoWord;	// Input FIFO head
	logic		fifoEmpty;
	logic		coderPop;
	logic		symValid;
	iqSymbol_t	sym;
	logic		phaseValid;
	phase_t		phase;
	logic		decPush;
	word_t		decWord;
	logic		outFull;

	////////////////////
	// Input side
	////////////////////
	wordFifo #(.DEPTH(`FIFO_DEPTH)) inFifo (
		.inClock	(inClock),
		.rst		(rst),
		.push		(inWrite),
		.pushData	(inData),
		.pop		(coderPop),
		.rdData		(fifoWord),
		.full		(inFull),
		.empty		(fifoEmpty)
	);

	qpskCoder coder0 (
		.inClock	(inClock),
		.rst		(rst),
		.rdData		(fifoWord),
		.empty		(fifoEmpty),
		.pop		(coderPop),
		.symValid	(symValid),
		.sym		(sym)
	);

	////////////////////
	// Receive side
	////////////////////
	cordicPhase cordic0 (
		.inClock	(inClock),
		.rst		(rst),
		.symValid	(symValid),
		.sym		(sym),
		.phaseValid	(phaseValid),
		.phase		(phase)
	);

	phaseDecoder decoder0 (
		.inClock	(inClock),
		.rst		(rst),
		.phaseValid	(phaseValid),
		.phase		(phase),
		.outFull	(outFull),
		.push		(decPush),
		.pushData	(decWord),
		.overflow	(overflow)
	);

	wordFifo #(.DEPTH(`FIFO_DEPTH)) outFifo (
		.inClock	(inClock),
		.rst		(rst),
		.push		(decPush),
		.pushData	(decWord),
		.pop		(outRead),
		.rdData		(outData),
		.full		(outFull),
		.empty		(outEmpty)
	);

endmodule

// ==== modemTb.sv ====
`timescale 1ns/1ps
`include "modem_defines.svh"

module modemTb;
	import modemPkg::*;

	localparam int WAIT_LIMIT = 400;	// Cycles allowed per wait loop
	localparam int NUM_VEC    = 16;		// Every 4-bit word once
	localparam int OVF_WORDS  = 12;		// Overflow case needs more than FIFO_DEPTH

	logic	inClock;
	logic	rst;
	logic	inWrite;
	word_t	inData;
	logic	inFull;
	logic	outRead;
	word_t	outData;
	logic	outEmpty;
	logic	overflow;
	int		pushCount;	// Decoder pushes since last rst
	int		seedDummy;	// Return of the seeding call

	// Readback equals the sent word as decoding inverts the symbol mapping
	word_t stimWord [NUM_VEC] = '{4'h0, 4'h5, 4'hA, 4'hF, 4'h1, 4'h2, 4'h4, 4'h8,
		4'h3, 4'h6, 4'hC, 4'h9, 4'h7, 4'hB, 4'hD, 4'hE};
	word_t expWord [NUM_VEC] = '{4'h0, 4'h5, 4'hA, 4'hF, 4'h1, 4'h2, 4'h4, 4'h8,
		4'h3, 4'h6, 4'hC, 4'h9, 4'h7, 4'hB, 4'hD, 4'hE};

	modemTop dut0 (
		.inClock	(inClock),
		.rst		(rst),
		.inWrite	(inWrite),
		.inData		(inData),
		.inFull		(inFull),
		.outRead	(outRead),
		.outData	(outData),
		.outEmpty	(outEmpty),
		.overflow	(overflow)
	);

	always #20 inClock = ~inClock;	// 40 ns period

	// Counts decoder pushes including dropped words
	always @(posedge inClock) begin
		if (rst) begin
			pushCount <= 0;
		end else if (dut0.decPush) begin
			pushCount <= pushCount + 1;
		end
	end

	////////////////////
	// Reporting
	////////////////////
	task automatic stopRun();
		$display("Verification failed");
		$fatal(1, "Simulation stopped at first error");
	endtask

	task automatic timeoutFail(input string what);
		$display("Timed out after %0d cycles waiting for %s", WAIT_LIMIT, what);
		stopRun();
	endtask

	task automatic checkWord(input word_t got, input word_t exp, input string what);
		if (got !== exp) begin
			$display("[FAIL] time %0t: %s, got %h expected %h", $time, what, got, exp);
			stopRun();
		end
	endtask

	task automatic checkFlag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("[FAIL] time %0t: %s, got %b expected %b", $time, what, got, exp);
			stopRun();
		end
	endtask

	////////////////////
	// Bus actions
	////////////////////
	task automatic applyReset();
		rst = 1'b1;
		repeat (8) @(negedge inClock);	// Held for 8 cycles
		rst = 1'b0;
	endtask

	task automatic idleGap();
		int gap;
		gap = $urandom_range(3, 0);	// Random spacing between writes
		repeat (gap) @(negedge inClock);
	endtask

	task automatic writeWord(input word_t w);
		int waited;
		waited = 0;
		while (inFull && waited < WAIT_LIMIT) begin	// Respect input back-pressure
			@(negedge inClock);
			waited++;
		end
		if (inFull) timeoutFail("inFull to clear");
		inWrite = 1'b1;
		inData  = w;
		@(negedge inClock);
		inWrite = 1'b0;
	endtask

	task automatic readWord(output word_t w);
		int waited;
		waited = 0;
		while (outEmpty && waited < WAIT_LIMIT) begin
			@(negedge inClock);
			waited++;
		end
		if (outEmpty) timeoutFail("outEmpty to fall");
		w       = outData;	// FWFT head is stable at the falling edge
		outRead = 1'b1;
		@(negedge inClock);
		outRead = 1'b0;
	endtask

	task automatic waitPushes(input int target);
		int waited;
		waited = 0;
		while (pushCount < target && waited < WAIT_LIMIT) begin
			@(negedge inClock);
			waited++;
		end
		if (pushCount < target) timeoutFail("all words to leave the decoder");
	endtask

	////////////////////
	// Main sequence
	////////////////////
	initial begin
		word_t	got;
		int		base;

		inClock = 1'b0;
		rst     = 1'b1;
		inWrite = 1'b0;
		inData  = '0;
		outRead = 1'b0;
		seedDummy = $urandom(32'h4652acc2);
		applyReset();

		// Idle state straight after reset
		checkFlag(outEmpty, 1'b1, "outEmpty after reset");
		checkFlag(inFull, 1'b0, "inFull after reset");
		checkFlag(overflow, 1'b0, "overflow after reset");

		// One word at a time through the whole chain
		for (int i = 0; i < NUM_VEC; i++) begin
			idleGap();
			writeWord(stimWord[i]);
			readWord(got);
			checkWord(got, expWord[i], "single word round trip");
		end
		checkFlag(overflow, 1'b0, "overflow after single words");

		// Back-to-back burst small enough for outFifo
		for (int i = 0; i < `FIFO_DEPTH; i++) begin
			writeWord(stimWord[NUM_VEC - 1 - i]);
		end
		for (int i = 0; i < `FIFO_DEPTH; i++) begin
			readWord(got);
			checkWord(got, expWord[NUM_VEC - 1 - i], "burst order and value");
		end
		checkFlag(outEmpty, 1'b1, "outEmpty after burst drain");
		checkFlag(overflow, 1'b0, "overflow after burst");

		// Twelve words with no reads drop the last four
		base = pushCount;
		for (int i = 0; i < OVF_WORDS; i++) begin
			writeWord(stimWord[i]);
		end
		waitPushes(base + OVF_WORDS);
		checkFlag(overflow, 1'b1, "overflow after filling outFifo");
		for (int i = 0; i < `FIFO_DEPTH; i++) begin
			readWord(got);
			checkWord(got, expWord[i], "kept word after overflow");
		end
		checkFlag(outEmpty, 1'b1, "outEmpty after kept words");

		// Leave words in both FIFOs so the reset has state to clear
		base = pushCount;
		writeWord(stimWord[1]);
		waitPushes(base + 1);		// First word now sits in outFifo
		checkFlag(outEmpty, 1'b0, "outEmpty before second reset");
		for (int i = 0; i < OVF_WORDS; i++) begin
			writeWord(stimWord[i]);	// Coder drains at most one word per 3 cycles
		end
		checkFlag(inFull, 1'b1, "inFull after back-to-back writes");

		// Sticky flag cleared only by rst
		applyReset();
		checkFlag(overflow, 1'b0, "overflow after second reset");
		checkFlag(outEmpty, 1'b1, "outEmpty after second reset");
		checkFlag(inFull, 1'b0, "inFull after second reset");
		writeWord(stimWord[10]);
		readWord(got);
		checkWord(got, expWord[10], "round trip after second reset");

		$display("Verification passed");
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+.
modemPkg.sv
wordFifo.sv
qpskCoder.sv
cordicPhase.sv
phaseDecoder.sv
modemTop.sv
modemTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the modem testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f vlog.f --top-module modemTb -o modemSim

# A failing run exits nonzero, the log search below decides the result
./obj_dir/modemSim > sim.log 2>&1 || true
cat sim.log

if grep -q "Verification passed" sim.log; then
	exit 0
else
	exit 1
fi
